//--- design/uartPkg.sv
////////////////////////////////////////
// uart line format package
// frame constants and serial-side types
////////////////////////////////////////

package uartPkg;

	////////////////////////////////////////
	// frame format
	////////////////////////////////////////

	localparam int dataBits    = 8;   // data bits per frame
	localparam int sbTick      = 16;  // ticks in the stop bit (one stop bit)
	localparam int overSample  = 16;  // ticks per bit

	// clk cycles between ticks
	// 4 x 16 gives 64 clocks per bit, 640 per frame
	localparam int clksPerTick = 4;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	// one data byte as it leaves or enters the line
	typedef logic [dataBits-1:0] uartByte;

	// sampling counter, counts ticks inside a bit
	typedef logic [3:0] tickCount;

	// data bit counter, 0..dataBits-1
	typedef logic [2:0] bitIndex;

endpackage

//--- design/hostPkg.sv
////////////////////////////////////////
// host side package
// fifo sizing and host status word
////////////////////////////////////////

package hostPkg;

	localparam int fifoDepth   = 16;  // bytes per fifo
	localparam int fifoAddrLen = 4;   // log2 of depth

	typedef logic [fifoAddrLen-1:0] fifoPtr;   // read/write address
	typedef logic [fifoAddrLen:0]   fifoCount; // occupancy, 0..fifoDepth

	// status word seen by the host
	typedef struct packed
	{
		logic rxEmpty;    // nothing to read
		logic txFull;     // writes will stall
		logic rxOverrun;  // sticky, a received byte was dropped
	} uartStatus;

endpackage

//--- design/baudTickGen.sv
////////////////////////////////////////
// baud tick generator
// one-cycle oversampling tick every clksPerTick clocks
////////////////////////////////////////

`timescale 1ns/1ps

module baudTickGen
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	import uartPkg::*;

	localparam int cntLen = $clog2(clksPerTick);

	logic [cntLen-1:0] divCnt;  // counts down to zero then reloads

	// free running, shared by rx and tx
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= cntLen'(clksPerTick - 1);
			tick   <= 1'b0;
		end
		else
		begin
			if (divCnt == '0)
				divCnt <= cntLen'(clksPerTick - 1);  // wrap
			else
				divCnt <= divCnt - 1'b1;
			tick <= (divCnt == '0);  // registered, one clk wide
		end
	end

endmodule

//--- design/uartRec.sv
////////////////////////////////////////
// uart receiver
// 16x oversampled 8N1 frames in, one recDone pulse per byte
////////////////////////////////////////

`timescale 1ns/1ps

module uartRec
(
	input  logic             clk,
	input  logic             reset,
	input  logic             tick,
	input  logic             rx,
	output logic             recDone,
	output uartPkg::uartByte recByte
);

	import uartPkg::*;

	typedef enum logic [1:0]
	{
		recIdle,
		recStart,
		recData,
		recStop
	} recState;

	// compare points for the sampling counter
	localparam tickCount midStart = tickCount'(overSample/2 - 1);  // middle of start bit
	localparam tickCount lastTick = tickCount'(overSample - 1);    // one full bit later
	localparam tickCount stopLast = tickCount'(sbTick - 1);
	localparam bitIndex  lastBit  = bitIndex'(dataBits - 1);

	recState  stateReg, stateNext;
	tickCount sReg, sNext;     // ticks inside current bit
	bitIndex  nReg, nNext;     // data bits taken so far
	uartByte  bReg, bNext;     // shift register filled lsb first

	////////////////////////////////////////
	// state registers
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= recIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	// received data byte
	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		recDone   = 1'b0;

		case (stateReg)
			recIdle:
				if (!rx)  // falling edge of start bit
				begin
					stateNext = recStart;
					sNext     = '0;
				end
			recStart:
				if (tick)
				begin
					// mid start moves on without a glitch check
					if (sReg == midStart)
					begin
						stateNext = recData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			recData:
				if (tick)
				begin
					if (sReg == lastTick)  // middle of next data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[dataBits-1:1]};
						if (nReg == lastBit)
							stateNext = recStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			recStop:
				if (tick)
				begin
					if (sReg == stopLast)
					begin
						stateNext = recIdle;
						recDone   = 1'b1;  // byte ready in bReg
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = recIdle;
		endcase
	end

	assign recByte = bReg;

endmodule

//--- design/uartTrans.sv
////////////////////////////////////////
// uart transmitter
// serializes fifo bytes as 8N1 frames
////////////////////////////////////////

`timescale 1ns/1ps

module uartTrans
(
	input  logic             clk,
	input  logic             reset,
	input  logic             tick,
	input  uartPkg::uartByte txHead,
	input  logic             txEmpty,
	output logic             txPop,
	output logic             tx
);

	import uartPkg::*;

	typedef enum logic [1:0]
	{
		trIdle,
		trStart,
		trData,
		trStop
	} transState;

	localparam tickCount lastTick = tickCount'(overSample - 1);
	localparam tickCount stopLast = tickCount'(sbTick - 1);
	localparam bitIndex  lastBit  = bitIndex'(dataBits - 1);

	transState stateReg, stateNext;
	tickCount  sReg, sNext;
	bitIndex   nReg, nNext;
	uartByte   shReg, shNext;   // byte being shifted out
	logic      txReg, txNext;   // registered line driver

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= trIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;  // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
		shReg <= shNext;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		shNext    = shReg;
		txNext    = txReg;
		txPop     = 1'b0;

		case (stateReg)
			trIdle:
			begin
				txNext = 1'b1;
				if (tick && !txEmpty)  // start bit lines up with a tick
				begin
					txPop     = 1'b1;
					shNext    = txHead;
					sNext     = '0;
					txNext    = 1'b0;
					stateNext = trStart;
				end
			end
			trStart:
				if (tick)
				begin
					if (sReg == lastTick)
					begin
						sNext     = '0;
						nNext     = '0;
						txNext    = shReg[0];  // first data bit, lsb
						stateNext = trData;
					end
					else
						sNext = sReg + 1'b1;
				end
			trData:
				if (tick)
				begin
					if (sReg == lastTick)
					begin
						sNext  = '0;
						shNext = shReg >> 1;
						if (nReg == lastBit)
						begin
							txNext    = 1'b1;  // stop bit
							stateNext = trStop;
						end
						else
						begin
							nNext  = nReg + 1'b1;
							txNext = shReg[1];
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			trStop:
				if (tick)
				begin
					if (sReg == stopLast)
					begin
						sNext = '0;
						// back to back frames, no extra idle tick
						if (!txEmpty)
						begin
							txPop     = 1'b1;
							shNext    = txHead;
							txNext    = 1'b0;
							stateNext = trStart;
						end
						else
							stateNext = trIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = trIdle;
		endcase
	end

	assign tx = txReg;

endmodule

//--- design/byteFifo.sv
////////////////////////////////////////
// byte fifo
// 16 deep, first word fall through, registered flags
////////////////////////////////////////

`timescale 1ns/1ps

module byteFifo
(
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic             pop,
	input  uartPkg::uartByte wrByte,
	output uartPkg::uartByte rdByte,
	output logic             full,
	output logic             empty
);

	import uartPkg::*;
	import hostPkg::*;

	uartByte  mem [fifoDepth];
	fifoPtr   wrPtr, rdPtr;
	fifoCount count, countNext;
	logic     doPush, doPop;

	// overflow and underflow requests are dropped
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	always_comb
	begin
		countNext = count;
		if (doPush && !doPop)
			countNext = count + 1'b1;
		else if (doPop && !doPush)
			countNext = count - 1'b1;
	end

	////////////////////////////////////////
	// pointers, count, flags
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;  // wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= countNext;
			full  <= (countNext == fifoCount'(fifoDepth));
			empty <= (countNext == '0);
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= wrByte;
	end

	assign rdByte = mem[rdPtr];  // head visible without a pop

endmodule

//--- design/uartHostPort.sv
////////////////////////////////////////
// host port
// four-phase req/ack channels to the fifos, status word
////////////////////////////////////////

`timescale 1ns/1ps

module uartHostPort
(
	input  logic               clk,
	input  logic               reset,
	input  logic               txReq,
	input  logic               rxReq,
	input  uartPkg::uartByte   txData,
	output logic               txAck,
	output logic               rxAck,
	output uartPkg::uartByte   rxData,
	input  logic               recDone,
	input  logic               rxFull,
	input  logic               rxEmpty,
	input  logic               txFull,
	output logic               rxPush,
	output logic               rxPop,
	output logic               txPush,
	input  uartPkg::uartByte   rxHead,
	output hostPkg::uartStatus status
);

	typedef enum logic
	{
		hsIdle,  // waiting for req
		hsAck    // transfer done, ack up until req drops
	} hsState;

	hsState txState, rxState;
	logic   overrunReg;

	////////////////////////////////////////
	// single cycle fifo strobes
	////////////////////////////////////////

	assign txPush = (txState == hsIdle) && txReq && !txFull;   // stalls while full
	assign rxPop  = (rxState == hsIdle) && rxReq && !rxEmpty;
	assign rxPush = recDone;  // fifo drops it when full

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			txState    <= hsIdle;
			rxState    <= hsIdle;
			rxData     <= '0;
			overrunReg <= 1'b0;
		end
		else
		begin
			// write channel
			if (txPush)
				txState <= hsAck;
			else if (txState == hsAck && !txReq)
				txState <= hsIdle;

			// read channel, byte held until next read
			if (rxPop)
			begin
				rxState <= hsAck;
				rxData  <= rxHead;
			end
			else if (rxState == hsAck && !rxReq)
				rxState <= hsIdle;

			if (recDone && rxFull)
				overrunReg <= 1'b1;  // sticky till reset
		end
	end

	assign txAck = (txState == hsAck);
	assign rxAck = (rxState == hsAck);

	// status word
	always_comb
	begin
		status.rxEmpty   = rxEmpty;
		status.txFull    = txFull;
		status.rxOverrun = overrunReg;
	end

endmodule

//--- design/uartCore.sv
////////////////////////////////////////
// uart core, top level
// tick gen, rx/tx engines, two fifos, host port
////////////////////////////////////////

`timescale 1ns/1ps

module uartCore
(
	input  logic               clk,
	input  logic               reset,
	input  logic               rx,
	output logic               tx,
	input  logic               txReq,
	input  uartPkg::uartByte   txData,
	output logic               txAck,
	input  logic               rxReq,
	output logic               rxAck,
	output uartPkg::uartByte   rxData,
	output hostPkg::uartStatus status
);

	import uartPkg::*;

	logic    tick;
	logic    recDone;
	uartByte recByte;
	uartByte rxHead, txHead;         // fifo heads
	logic    rxPush, rxPop, rxFull, rxEmpty;
	logic    txPush, txPop, txFull, txEmpty;

	baudTickGen tickGen_inst
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	////////////////////////////////////////
	// receive path
	////////////////////////////////////////

	uartRec uartRec_inst
	(
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.rx      (rx),
		.recDone (recDone),
		.recByte (recByte)
	);

	byteFifo rxFifo
	(
		.clk    (clk),
		.reset  (reset),
		.push   (rxPush),
		.pop    (rxPop),
		.wrByte (recByte),
		.rdByte (rxHead),
		.full   (rxFull),
		.empty  (rxEmpty)
	);

	////////////////////////////////////////
	// transmit path
	////////////////////////////////////////

	byteFifo txFifo
	(
		.clk    (clk),
		.reset  (reset),
		.push   (txPush),
		.pop    (txPop),
		.wrByte (txData),
		.rdByte (txHead),
		.full   (txFull),
		.empty  (txEmpty)
	);

	uartTrans uartTrans_inst
	(
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.txHead  (txHead),
		.txEmpty (txEmpty),
		.txPop   (txPop),
		.tx      (tx)
	);

	// host handshakes and status
	uartHostPort hostPort_inst
	(
		.clk     (clk),
		.reset   (reset),
		.txReq   (txReq),
		.rxReq   (rxReq),
		.txData  (txData),
		.txAck   (txAck),
		.rxAck   (rxAck),
		.rxData  (rxData),
		.recDone (recDone),
		.rxFull  (rxFull),
		.rxEmpty (rxEmpty),
		.txFull  (txFull),
		.rxPush  (rxPush),
		.rxPop   (rxPop),
		.txPush  (txPush),
		.rxHead  (rxHead),
		.status  (status)
	);

endmodule

//--- sim/uartCoreTb.sv
////////////////////////////////////////
// uart core testbench
// loopback, serial rx, overrun and tx back-pressure
////////////////////////////////////////

`timescale 1ns/1ps

module uartCoreTb;

	import uartPkg::*;
	import hostPkg::*;

	localparam int bitClks    = overSample * clksPerTick;  // 64 clocks per bit
	localparam int cycleLimit = 60000;  // ~60 frames of 640 clocks plus margin

	logic      clk;
	logic      reset;
	logic      rxDrv;     // serial line from the tb side
	logic      loopEn;    // tx wired back to rx
	logic      rx;
	logic      tx;
	logic      txReq, rxReq;
	logic      txAck, rxAck;
	uartByte   txData, rxData;
	uartStatus status;

	uartByte   expQ[$];     // bytes expected from reads
	uartByte   gotQ[$];     // bytes returned by reads, not yet compared
	uartByte   txExpQ[$];   // bytes written, not yet seen on tx
	uartStatus statQ[$];    // pending status checks
	logic      ovrExp;
	logic      sawFull;
	logic [31:0] lfsrState;
	int        cycleCount, errCount, errAtStart, checkCount, testCount;

	assign rx = loopEn ? tx : rxDrv;

	uartCore uartCore_inst
	(
		.clk    (clk),
		.reset  (reset),
		.rx     (rx),
		.tx     (tx),
		.txReq  (txReq),
		.txData (txData),
		.txAck  (txAck),
		.rxReq  (rxReq),
		.rxAck  (rxAck),
		.rxData (rxData),
		.status (status)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic uartByte nextByte();
		uartByte b;
		b = '0;
		for (int i = 0; i < dataBits; i++)
		begin
			lfsrState = lfsrStep(lfsrState);  // one step per bit
			b = {b[dataBits-2:0], lfsrState[0]};
		end
		return b;
	endfunction

	// status from what the host side should see
	function automatic uartStatus expectStatus(int rxLen, int txPending, logic ovr);
		uartStatus s;
		s.rxEmpty   = (rxLen == 0);
		s.txFull    = (txPending >= fifoDepth);
		s.rxOverrun = ovr;
		return s;
	endfunction

	task automatic reportError(string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errCount++;
	endtask

	task automatic checkByte(string name, uartByte got, uartByte exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkStatus(uartStatus got, uartStatus exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("FAIL %0t status got %b expected %b", $time, got, exp);
			errCount++;
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			errCount++;
		end
	endtask

	// compare process, runs mid cycle after the drivers
	initial
	begin
		uartByte got;
		forever
		begin
			@(posedge clk);
			#20;
			while (gotQ.size() > 0)
			begin
				got = gotQ.pop_front();
				if (expQ.size() == 0)
					reportError("a read returned a byte that was never sent");
				else
					checkByte("rxData", got, expQ.pop_front());
			end
			while (statQ.size() > 0)
				checkStatus(status, statQ.pop_front());
		end
	end

	// tx line monitor, decodes each frame at mid bit
	initial
	begin
		uartByte b;
		forever
		begin
			@(negedge tx);
			repeat (bitClks / 2) @(posedge clk);
			for (int i = 0; i < dataBits; i++)
			begin
				repeat (bitClks) @(posedge clk);
				#10;
				b[i] = tx;  // lsb first
			end
			repeat (bitClks) @(posedge clk);
			#10;
			if (tx !== 1'b1)
				reportError("stop bit on tx was not high");
			if (txExpQ.size() == 0)
				reportError("a frame appeared on tx that was never written");
			else
				checkByte("tx", b, txExpQ.pop_front());
		end
	end

	////////////////////////////////////////
	// stimulus tasks, all start at +10 ns
	////////////////////////////////////////

	task automatic writeByte(input uartByte b, output int waitCycles);
		txData     = b;
		txReq      = 1'b1;
		waitCycles = 0;
		do
		begin
			@(posedge clk);
			#10;
			waitCycles++;
			if (status.txFull)
				sawFull = 1'b1;
		end while (!txAck);
		txExpQ.push_back(b);
		if (loopEn)
			expQ.push_back(b);  // comes back through rx
		txReq = 1'b0;
		do
		begin
			@(posedge clk);
			#10;
		end while (txAck);
	endtask

	task automatic readByte();
		rxReq = 1'b1;
		do
		begin
			@(posedge clk);
			#10;
		end while (!rxAck);
		gotQ.push_back(rxData);
		rxReq = 1'b0;
		do
		begin
			@(posedge clk);
			#10;
		end while (rxAck);
	endtask

	// 8N1 frame on rxDrv
	task automatic sendFrame(uartByte b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rxDrv = bits[i];
			repeat (bitClks) @(posedge clk);
			#10;
		end
	endtask

	task automatic requestStatus();
		statQ.push_back(expectStatus(expQ.size(), txExpQ.size(), ovrExp));
		@(posedge clk);
		#10;
	endtask

	task automatic waitTxDrained();
		while (txExpQ.size() > 0)
			@(posedge clk);
		@(posedge clk);
		#10;
	endtask

	task automatic finishTest(string name);
		testCount++;
		if (errCount == errAtStart)
			$display("test %0d %s: passed", testCount, name);
		else
			$display("test %0d %s: failed with %0d errors", testCount, name,
				errCount - errAtStart);
		errAtStart = errCount;
	endtask

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	initial
	begin
		while (cycleCount < cycleLimit)
			@(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Something failed");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		int      waitCycles;
		int      maxWait;
		uartByte b;

		reset      = 1'b1;
		txReq      = 1'b0;
		rxReq      = 1'b0;
		txData     = '0;
		rxDrv      = 1'b1;  // idle line
		loopEn     = 1'b0;
		ovrExp     = 1'b0;
		sawFull    = 1'b0;
		lfsrState  = 32'h69fa;
		cycleCount = 0;
		errCount   = 0;
		errAtStart = 0;
		checkCount = 0;
		testCount  = 0;
		maxWait    = 0;
		repeat (16) @(posedge clk);
		#10;
		reset = 1'b0;
		@(posedge clk);
		#10;

		// 1 reset values
		checkBit("tx", tx, 1'b1);
		checkBit("txAck", txAck, 1'b0);
		checkBit("rxAck", rxAck, 1'b0);
		requestStatus();
		finishTest("reset state");

		// 2 single byte through the loop
		loopEn = 1'b1;
		writeByte(nextByte(), waitCycles);
		readByte();
		waitTxDrained();
		requestStatus();
		finishTest("single loopback");

		// 3 burst, reads overlap the writes
		fork
			for (int i = 0; i < 8; i++)
				writeByte(nextByte(), waitCycles);
			for (int i = 0; i < 8; i++)
				readByte();
		join
		waitTxDrained();
		requestStatus();
		finishTest("burst loopback");

		// 4 frames from the tb serial driver
		loopEn = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			b = nextByte();
			expQ.push_back(b);
			sendFrame(b);
		end
		for (int i = 0; i < 4; i++)
			readByte();
		requestStatus();
		finishTest("serial receive");

		// 5 seventeen frames into a 16 deep fifo
		for (int i = 0; i < 17; i++)
		begin
			b = nextByte();
			if (i < fifoDepth)
				expQ.push_back(b);  // last one gets dropped
			sendFrame(b);
		end
		ovrExp = 1'b1;
		requestStatus();
		for (int i = 0; i < fifoDepth; i++)
			readByte();
		requestStatus();  // empty again, 17th never shows up
		finishTest("overrun");

		// 6 eighteen writes against a busy transmitter
		sawFull = 1'b0;
		for (int i = 0; i < 18; i++)
		begin
			writeByte(nextByte(), waitCycles);
			if (waitCycles > maxWait)
				maxWait = waitCycles;
		end
		if (!sawFull)
			reportError("txFull never rose during the write burst");
		if (maxWait < bitClks)
			reportError("txAck was not held back while the transmit FIFO was full");
		waitTxDrained();
		requestStatus();
		finishTest("transmit back-pressure");

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- filelist.f
design/uartPkg.sv
design/hostPkg.sv
design/baudTickGen.sv
design/uartRec.sv
design/uartTrans.sv
design/byteFifo.sv
design/uartHostPort.sv
design/uartCore.sv
sim/uartCoreTb.sv

//--- Makefile
# Verilator build and run for the uart core testbench

VERILATOR ?= verilator
TOP       ?= uartCoreTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
